/* isa_pkg.sv */
package isa_pkg;

  localparam int word_w    = 16;
  localparam int reg_idx_w = 3;
  localparam int op6_w     = 6;

  // Major opcode in instr_word[15:12]
  localparam logic [3:0] op_add = 4'd0;
  localparam logic [3:0] op_adi = 4'd1;
  localparam logic [3:0] op_ndu = 4'd2;
  localparam logic [3:0] op_lhi = 4'd3;
  localparam logic [3:0] op_lw  = 4'd4;
  localparam logic [3:0] op_sw  = 4'd5;
  localparam logic [3:0] op_lm  = 4'd6;
  localparam logic [3:0] op_sm  = 4'd7;
  localparam logic [3:0] op_beq = 4'd12;
  localparam logic [3:0] op_jal = 4'd8;
  localparam logic [3:0] op_jlr = 4'd9;

  // Condition field in instr_word[1:0]
  localparam logic [1:0] cond_none  = 2'b00;
  localparam logic [1:0] cond_zero  = 2'b01;
  localparam logic [1:0] cond_carry = 2'b10;

  localparam logic [op6_w-1:0] op6_illegal = '1;

  // PC source select
  localparam logic [1:0] pc_sel_seq        = 2'b00;
  localparam logic [1:0] pc_sel_branch_imm = 2'b01;
  localparam logic [1:0] pc_sel_reg        = 2'b10;

  // Write-back select
  localparam logic [1:0] wb_sel_alu = 2'b00;
  localparam logic [1:0] wb_sel_pc  = 2'b01;
  localparam logic [1:0] wb_sel_imm = 2'b10;
  localparam logic [1:0] wb_sel_mem = 2'b11;

  localparam logic [reg_idx_w-1:0] r7_idx = 3'd7; // PC lives in R7

  typedef enum logic [3:0] {
    cls_add,
    cls_adc,
    cls_adz,
    cls_ndu,
    cls_ndc,
    cls_ndz,
    cls_adi,
    cls_lhi,
    cls_lw,
    cls_sw,
    cls_beq,
    cls_jal,
    cls_jlr,
    cls_lm,
    cls_sm,
    cls_illegal
  } instr_class_t;

endpackage

/* reg_field_decode.sv */
`timescale 1ns/1ns

module reg_field_decode import isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  logic [word_w-1:0]    instr_word,
  output logic                 s1_valid,
  output instr_class_t         s1_class,
  output logic [reg_idx_w-1:0] rs1,
  output logic [reg_idx_w-1:0] rs2,
  output logic [reg_idx_w-1:0] rd,
  output logic                 rs1_valid,
  output logic                 rs2_valid,
  output logic                 rd_valid,
  output logic                 r7_dest
);

  logic [3:0]           major;
  logic [1:0]           cond;
  instr_class_t         cls_d;
  logic [reg_idx_w-1:0] rs1_d, rs2_d, rd_d;
  logic                 rs1_valid_d, rs2_valid_d, rd_valid_d;
  logic                 r7_dest_d;

  assign major = instr_word[15:12];
  assign cond  = instr_word[1:0];

  // Opcode and condition to class
  always_comb begin
    case (major)
      op_add: begin
        case (cond)
          cond_none:  cls_d = cls_add;
          cond_carry: cls_d = cls_adc;
          cond_zero:  cls_d = cls_adz;
          default:    cls_d = cls_illegal;
        endcase
      end
      op_ndu: begin
        case (cond)
          cond_none:  cls_d = cls_ndu;
          cond_carry: cls_d = cls_ndc;
          cond_zero:  cls_d = cls_ndz;
          default:    cls_d = cls_illegal;
        endcase
      end
      op_adi:  cls_d = cls_adi;
      op_lhi:  cls_d = cls_lhi;
      op_lw:   cls_d = cls_lw;
      op_sw:   cls_d = cls_sw;
      op_lm:   cls_d = cls_lm;
      op_sm:   cls_d = cls_sm;
      op_beq:  cls_d = cls_beq;
      op_jal:  cls_d = cls_jal;
      op_jlr:  cls_d = cls_jlr;
      default: cls_d = cls_illegal; // Opcodes 10, 11, 13-15
    endcase
  end

  // Register field placement per group
  always_comb begin
    rs1_d       = '0;
    rs2_d       = '0;
    rd_d        = '0;
    rs1_valid_d = 1'b0;
    rs2_valid_d = 1'b0;
    rd_valid_d  = 1'b0;
    case (cls_d)
      cls_add, cls_adc, cls_adz, cls_ndu, cls_ndc, cls_ndz: begin
        rs1_d       = instr_word[11:9];
        rs2_d       = instr_word[8:6];
        rd_d        = instr_word[5:3];
        rs1_valid_d = 1'b1;
        rs2_valid_d = 1'b1;
        rd_valid_d  = 1'b1;
      end
      cls_adi: begin
        rs1_d       = instr_word[11:9];
        rd_d        = instr_word[8:6];
        rs1_valid_d = 1'b1;
        rd_valid_d  = 1'b1;
      end
      cls_lw: begin
        rs1_d       = instr_word[8:6]; // Base register
        rd_d        = instr_word[11:9];
        rs1_valid_d = 1'b1;
        rd_valid_d  = 1'b1;
      end
      cls_sw: begin
        rs1_d       = instr_word[8:6];
        rs2_d       = instr_word[11:9]; // Store data
        rs1_valid_d = 1'b1;
        rs2_valid_d = 1'b1;
      end
      cls_beq: begin
        rs1_d       = instr_word[11:9];
        rs2_d       = instr_word[8:6];
        rs1_valid_d = 1'b1;
        rs2_valid_d = 1'b1;
      end
      cls_lhi, cls_jal: begin
        rd_d       = instr_word[11:9];
        rd_valid_d = 1'b1;
      end
      cls_jlr: begin
        rs2_d       = instr_word[8:6];
        rd_d        = instr_word[11:9];
        rs2_valid_d = 1'b1;
        rd_valid_d  = 1'b1;
      end
      cls_lm: begin
        rs1_d       = instr_word[11:9];
        rs1_valid_d = 1'b1;
        rd_valid_d  = 1'b1; // Index filled in later by the LM/SM sequencer
      end
      cls_sm: begin
        rs1_d       = instr_word[11:9];
        rs1_valid_d = 1'b1;
        rs2_valid_d = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign r7_dest_d = rd_valid_d && (rd_d == r7_idx) && (cls_d != cls_lm) && (cls_d != cls_sm);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      s1_class  <= cls_d;
      rs1       <= rs1_d;
      rs2       <= rs2_d;
      rd        <= rd_d;
      rs1_valid <= rs1_valid_d;
      rs2_valid <= rs2_valid_d;
      rd_valid  <= rd_valid_d;
      r7_dest   <= r7_dest_d;
    end
  end

endmodule

/* control_decode.sv */
`timescale 1ns/1ns

module control_decode import isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 s1_valid,
  input  instr_class_t         s1_class,
  input  logic [reg_idx_w-1:0] s1_rs1,
  input  logic [reg_idx_w-1:0] s1_rs2,
  input  logic [reg_idx_w-1:0] s1_rd,
  input  logic                 s1_rs1_valid,
  input  logic                 s1_rs2_valid,
  input  logic                 s1_rd_valid,
  input  logic                 s1_r7_dest,
  output logic                 out_valid,
  output logic [op6_w-1:0]     opcode,
  output logic                 lm_sm,
  output logic                 se6_se9_sel,
  output logic                 alu_op,
  output logic                 modify_carry,
  output logic                 modify_zero,
  output logic [1:0]           cond_sel,
  output logic [1:0]           pc_sel,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic [1:0]           wb_sel,
  output logic                 reg_write,
  output logic [reg_idx_w-1:0] rs1,
  output logic [reg_idx_w-1:0] rs2,
  output logic [reg_idx_w-1:0] rd,
  output logic                 rs1_valid,
  output logic                 rs2_valid,
  output logic                 rd_valid,
  output logic                 r7_dest
);

  logic [1:0]       cond_d;
  logic [op6_w-1:0] opcode_d;
  logic             lm_sm_d, se6_se9_sel_d, alu_op_d;
  logic             modify_carry_d, modify_zero_d;
  logic [1:0]       cond_sel_d, pc_sel_d, wb_sel_d;
  logic             mem_read_d, mem_write_d, reg_write_d;

  // Condition code recovered from the class
  always_comb begin
    case (s1_class)
      cls_adc, cls_ndc: cond_d = cond_carry;
      cls_adz, cls_ndz: cond_d = cond_zero;
      default:          cond_d = cond_none;
    endcase
  end

  always_comb begin
    opcode_d       = op6_illegal;
    lm_sm_d        = 1'b0;
    se6_se9_sel_d  = 1'b0;
    alu_op_d       = 1'b0;
    modify_carry_d = 1'b0;
    modify_zero_d  = 1'b0;
    cond_sel_d     = cond_none;
    pc_sel_d       = pc_sel_seq;
    mem_read_d     = 1'b0;
    mem_write_d    = 1'b0;
    wb_sel_d       = wb_sel_alu;
    reg_write_d    = 1'b0;
    case (s1_class)
      cls_add, cls_adc, cls_adz: begin
        opcode_d       = {op_add, cond_d};
        modify_carry_d = 1'b1;
        modify_zero_d  = 1'b1;
        cond_sel_d     = cond_d;
        reg_write_d    = 1'b1;
      end
      cls_ndu, cls_ndc, cls_ndz: begin
        opcode_d      = {op_ndu, cond_d};
        alu_op_d      = 1'b1; // NAND
        modify_zero_d = 1'b1;
        cond_sel_d    = cond_d;
        reg_write_d   = 1'b1;
      end
      cls_adi: begin
        opcode_d       = {op_adi, 2'b00};
        modify_carry_d = 1'b1;
        modify_zero_d  = 1'b1;
        reg_write_d    = 1'b1;
      end
      cls_lhi: begin
        opcode_d      = {op_lhi, 2'b00};
        se6_se9_sel_d = 1'b1; // 9-bit immediate
        wb_sel_d      = wb_sel_imm;
        reg_write_d   = 1'b1;
      end
      cls_lw: begin
        opcode_d    = {op_lw, 2'b00};
        mem_read_d  = 1'b1;
        wb_sel_d    = wb_sel_mem;
        reg_write_d = 1'b1;
      end
      cls_sw: begin
        opcode_d    = {op_sw, 2'b00};
        mem_write_d = 1'b1;
      end
      cls_beq: begin
        opcode_d = {op_beq, 2'b00};
        pc_sel_d = pc_sel_branch_imm;
      end
      cls_jal: begin
        opcode_d      = {op_jal, 2'b00};
        se6_se9_sel_d = 1'b1;
        pc_sel_d      = pc_sel_branch_imm;
        wb_sel_d      = wb_sel_pc; // Link address
        reg_write_d   = 1'b1;
      end
      cls_jlr: begin
        opcode_d    = {op_jlr, 2'b00};
        pc_sel_d    = pc_sel_reg;
        wb_sel_d    = wb_sel_pc;
        reg_write_d = 1'b1;
      end
      cls_lm: begin
        opcode_d   = {op_lm, 2'b00};
        lm_sm_d    = 1'b1;
        mem_read_d = 1'b1;
        wb_sel_d   = wb_sel_mem;
      end
      cls_sm: begin
        opcode_d = {op_sm, 2'b00};
        lm_sm_d  = 1'b1; // Write strobe comes from the sequencer
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      lm_sm     <= 1'b0;
      mem_read  <= 1'b0;
      mem_write <= 1'b0;
      reg_write <= 1'b0;
    end else begin
      out_valid <= s1_valid;
      if (s1_valid) begin
        lm_sm     <= lm_sm_d;
        mem_read  <= mem_read_d;
        mem_write <= mem_write_d;
        reg_write <= reg_write_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      opcode       <= opcode_d;
      se6_se9_sel  <= se6_se9_sel_d;
      alu_op       <= alu_op_d;
      modify_carry <= modify_carry_d;
      modify_zero  <= modify_zero_d;
      cond_sel     <= cond_sel_d;
      pc_sel       <= pc_sel_d;
      wb_sel       <= wb_sel_d;
      rs1          <= s1_rs1;
      rs2          <= s1_rs2;
      rd           <= s1_rd;
      rs1_valid    <= s1_rs1_valid;
      rs2_valid    <= s1_rs2_valid;
      rd_valid     <= s1_rd_valid;
      r7_dest      <= s1_r7_dest;
    end
  end

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder import isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  logic [word_w-1:0]    instr_word,
  output logic                 out_valid,
  output logic [op6_w-1:0]     opcode,
  output logic                 lm_sm,
  output logic                 se6_se9_sel,
  output logic                 alu_op,
  output logic                 modify_carry,
  output logic                 modify_zero,
  output logic [1:0]           cond_sel,
  output logic [1:0]           pc_sel,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic [1:0]           wb_sel,
  output logic                 reg_write,
  output logic [reg_idx_w-1:0] rs1,
  output logic [reg_idx_w-1:0] rs2,
  output logic [reg_idx_w-1:0] rd,
  output logic                 rs1_valid,
  output logic                 rs2_valid,
  output logic                 rd_valid,
  output logic                 r7_dest
);

  logic                 s1_valid;
  instr_class_t         s1_class;
  logic [reg_idx_w-1:0] s1_rs1, s1_rs2, s1_rd;
  logic                 s1_rs1_valid, s1_rs2_valid, s1_rd_valid;
  logic                 s1_r7_dest;

  reg_field_decode field_dec_i ( // Stage one
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_word  (instr_word),
    .s1_valid    (s1_valid),
    .s1_class    (s1_class),
    .rs1         (s1_rs1),
    .rs2         (s1_rs2),
    .rd          (s1_rd),
    .rs1_valid   (s1_rs1_valid),
    .rs2_valid   (s1_rs2_valid),
    .rd_valid    (s1_rd_valid),
    .r7_dest     (s1_r7_dest)
  );

  control_decode ctrl_dec_i ( // Stage two
    .clk          (clk),
    .rst_n        (rst_n),
    .s1_valid     (s1_valid),
    .s1_class     (s1_class),
    .s1_rs1       (s1_rs1),
    .s1_rs2       (s1_rs2),
    .s1_rd        (s1_rd),
    .s1_rs1_valid (s1_rs1_valid),
    .s1_rs2_valid (s1_rs2_valid),
    .s1_rd_valid  (s1_rd_valid),
    .s1_r7_dest   (s1_r7_dest),
    .out_valid    (out_valid),
    .opcode       (opcode),
    .lm_sm        (lm_sm),
    .se6_se9_sel  (se6_se9_sel),
    .alu_op       (alu_op),
    .modify_carry (modify_carry),
    .modify_zero  (modify_zero),
    .cond_sel     (cond_sel),
    .pc_sel       (pc_sel),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .wb_sel       (wb_sel),
    .reg_write    (reg_write),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .rs1_valid    (rs1_valid),
    .rs2_valid    (rs2_valid),
    .rd_valid     (rd_valid),
    .r7_dest      (r7_dest)
  );

endmodule

/* instr_decoder_sva.sv */
`timescale 1ns/1ns

module instr_decoder_sva (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  input logic out_valid,
  input logic mem_read,
  input logic mem_write,
  input logic reg_write,
  input logic rd_valid
);

  // Two-stage latency with nothing lost or extra
  assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(instr_valid, 2))
    else $error("out_valid does not follow instr_valid by 2 cycles");

  assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else $error("out_valid high in the cycle after reset");

  assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write))
    else $error("mem_read and mem_write high together");

  assert property (@(posedge clk) disable iff (!rst_n) reg_write |-> rd_valid)
    else $error("reg_write without rd_valid");

endmodule

bind instr_decoder instr_decoder_sva sva_i (.*);

/* decode_checker.sv */
`timescale 1ns/1ns

module decode_checker import isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  logic [word_w-1:0]    instr_word,
  input  logic                 out_valid,
  input  logic [op6_w-1:0]     opcode,
  input  logic                 lm_sm, se6_se9_sel, alu_op, modify_carry, modify_zero,
  input  logic [1:0]           cond_sel, pc_sel, wb_sel,
  input  logic                 mem_read, mem_write, reg_write,
  input  logic [reg_idx_w-1:0] rs1, rs2, rd,
  input  logic                 rs1_valid, rs2_valid, rd_valid, r7_dest,
  output int                   in_flight
);

  typedef struct packed {
    logic [op6_w-1:0]     opcode;
    logic                 lm_sm;
    logic                 se6_se9_sel;
    logic                 alu_op;
    logic                 modify_carry;
    logic                 modify_zero;
    logic [1:0]           cond_sel;
    logic [1:0]           pc_sel;
    logic                 mem_read;
    logic                 mem_write;
    logic [1:0]           wb_sel;
    logic                 reg_write;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rd;
    logic                 rs1_valid;
    logic                 rs2_valid;
    logic                 rd_valid;
    logic                 r7_dest;
  } decode_t;

  decode_t           exp_q[$];
  logic [word_w-1:0] word_q[$];
  int                stamp_q[$];
  int                cycle_count     = 0;
  int                compared        = 0;
  int                mismatch_errors = 0;
  int                protocol_errors = 0;
  logic              after_reset     = 1'b0;

  function automatic decode_t decode_ref(input logic [word_w-1:0] w);
    decode_t    r;
    logic [3:0] major;
    logic [1:0] cond;
    logic       arith;
    logic       legal;
    r     = '0;
    major = w[15:12];
    cond  = w[1:0];
    arith = (major == op_add) || (major == op_ndu);
    legal = 1'b1;
    case (major)
      op_add, op_ndu: begin
        if (cond == 2'b11) begin
          legal = 1'b0;
        end else begin
          r.modify_carry = (major == op_add);
          r.modify_zero  = 1'b1;
          r.alu_op       = (major == op_ndu);
          r.cond_sel     = cond;
          r.reg_write    = 1'b1;
          {r.rs1, r.rs2, r.rd} = w[11:3];
          {r.rs1_valid, r.rs2_valid, r.rd_valid} = 3'b111;
        end
      end
      op_adi: begin
        {r.modify_carry, r.modify_zero, r.reg_write} = 3'b111;
        {r.rs1, r.rd} = w[11:6];
        {r.rs1_valid, r.rd_valid} = 2'b11;
      end
      op_lhi: begin
        {r.se6_se9_sel, r.reg_write, r.rd_valid} = 3'b111;
        r.wb_sel = wb_sel_imm;
        r.rd     = w[11:9];
      end
      op_lw: begin
        {r.mem_read, r.reg_write, r.rs1_valid, r.rd_valid} = 4'b1111;
        r.wb_sel = wb_sel_mem;
        r.rs1    = w[8:6];
        r.rd     = w[11:9];
      end
      op_sw: begin
        {r.mem_write, r.rs1_valid, r.rs2_valid} = 3'b111;
        r.rs1 = w[8:6];
        r.rs2 = w[11:9];
      end
      op_beq: begin
        r.pc_sel = pc_sel_branch_imm;
        {r.rs1, r.rs2} = w[11:6];
        {r.rs1_valid, r.rs2_valid} = 2'b11;
      end
      op_jal: begin
        {r.se6_se9_sel, r.reg_write, r.rd_valid} = 3'b111;
        r.pc_sel = pc_sel_branch_imm;
        r.wb_sel = wb_sel_pc;
        r.rd     = w[11:9];
      end
      op_jlr: begin
        {r.reg_write, r.rs2_valid, r.rd_valid} = 3'b111;
        r.pc_sel = pc_sel_reg;
        r.wb_sel = wb_sel_pc;
        r.rs2    = w[8:6];
        r.rd     = w[11:9];
      end
      op_lm: begin
        {r.lm_sm, r.mem_read, r.rs1_valid, r.rd_valid} = 4'b1111; // rd index stays 0
        r.wb_sel = wb_sel_mem;
        r.rs1    = w[11:9];
      end
      op_sm: begin
        {r.lm_sm, r.rs1_valid, r.rs2_valid} = 3'b111; // rs2 index stays 0
        r.rs1 = w[11:9];
      end
      default: legal = 1'b0;
    endcase
    r.opcode  = legal ? {major, (arith ? cond : 2'b00)} : op6_illegal;
    r.r7_dest = r.rd_valid && (r.rd == r7_idx) && (major != op_lm) && (major != op_sm);
    return r;
  endfunction

  task automatic check_field(input string name, input logic [7:0] got_v,
                             input logic [7:0] exp_v, input logic [word_w-1:0] word);
    if (got_v !== exp_v) begin
      mismatch_errors++;
      $display("Fail %0t ns: %s is %0h, expected %0h, instr %h", $time, name, got_v, exp_v, word);
    end
  endtask

  task automatic compare_result(input decode_t got, input decode_t exp, input logic [word_w-1:0] w);
    check_field("opcode", 8'(got.opcode), 8'(exp.opcode), w);
    check_field("lm_sm", 8'(got.lm_sm), 8'(exp.lm_sm), w);
    check_field("se6_se9_sel", 8'(got.se6_se9_sel), 8'(exp.se6_se9_sel), w);
    check_field("alu_op", 8'(got.alu_op), 8'(exp.alu_op), w);
    check_field("modify_carry", 8'(got.modify_carry), 8'(exp.modify_carry), w);
    check_field("modify_zero", 8'(got.modify_zero), 8'(exp.modify_zero), w);
    check_field("cond_sel", 8'(got.cond_sel), 8'(exp.cond_sel), w);
    check_field("pc_sel", 8'(got.pc_sel), 8'(exp.pc_sel), w);
    check_field("mem_read", 8'(got.mem_read), 8'(exp.mem_read), w);
    check_field("mem_write", 8'(got.mem_write), 8'(exp.mem_write), w);
    check_field("wb_sel", 8'(got.wb_sel), 8'(exp.wb_sel), w);
    check_field("reg_write", 8'(got.reg_write), 8'(exp.reg_write), w);
    check_field("rs1", 8'(got.rs1), 8'(exp.rs1), w);
    check_field("rs2", 8'(got.rs2), 8'(exp.rs2), w);
    check_field("rd", 8'(got.rd), 8'(exp.rd), w);
    check_field("rs1_valid", 8'(got.rs1_valid), 8'(exp.rs1_valid), w);
    check_field("rs2_valid", 8'(got.rs2_valid), 8'(exp.rs2_valid), w);
    check_field("rd_valid", 8'(got.rd_valid), 8'(exp.rd_valid), w);
    check_field("r7_dest", 8'(got.r7_dest), 8'(exp.r7_dest), w);
  endtask

  always @(posedge clk) begin : watch_proc
    decode_t got;
    if (!rst_n) begin
      after_reset = 1'b1;
    end else begin
      if (after_reset && ({out_valid, mem_read, mem_write, reg_write, lm_sm} !== 5'b0)) begin
        protocol_errors++;
        $display("Strobes were not low in the first cycle after reset at %0t ns", $time);
      end
      after_reset = 1'b0;
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          protocol_errors++;
          $display("An output appeared at %0t ns with no instruction pending", $time);
        end else begin
          got = {opcode, lm_sm, se6_se9_sel, alu_op, modify_carry, modify_zero, cond_sel,
                 pc_sel, mem_read, mem_write, wb_sel, reg_write, rs1, rs2, rd,
                 rs1_valid, rs2_valid, rd_valid, r7_dest};
          if (cycle_count - stamp_q[0] != 2) begin
            mismatch_errors++;
            $display("Fail %0t ns: latency is %0d cycles, expected 2, instr %h",
                     $time, cycle_count - stamp_q[0], word_q[0]);
          end
          compare_result(got, exp_q[0], word_q[0]);
          compared++;
          void'(exp_q.pop_front());
          void'(word_q.pop_front());
          void'(stamp_q.pop_front());
        end
      end
      if (instr_valid) begin
        exp_q.push_back(decode_ref(instr_word));
        word_q.push_back(instr_word);
        stamp_q.push_back(cycle_count);
      end
      in_flight <= exp_q.size();
    end
    cycle_count++;
  end

  task automatic close_report(output int total);
    if (exp_q.size() != 0) begin
      protocol_errors++;
      $display("%0d instructions never produced an output", exp_q.size());
    end
    total = mismatch_errors + protocol_errors;
    $display("Results compared %0d, value mismatches %0d, protocol errors %0d",
             compared, mismatch_errors, protocol_errors);
  endtask

endmodule

/* tb_instr_decoder.sv */
`timescale 1ns/1ns

module tb_instr_decoder import isa_pkg::*; ();

  localparam int clk_period     = 100;
  localparam int reset_cycles   = 4;
  localparam int directed_words = 64;
  localparam int random_words   = 400;
  localparam int stim_cycles    = reset_cycles + directed_words + 2 * random_words; // Gap worst case

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  logic [word_w-1:0]    instr_word;
  logic                 out_valid;
  logic [op6_w-1:0]     opcode;
  logic                 lm_sm, se6_se9_sel, alu_op, modify_carry, modify_zero;
  logic [1:0]           cond_sel, pc_sel, wb_sel;
  logic                 mem_read, mem_write, reg_write;
  logic [reg_idx_w-1:0] rs1, rs2, rd;
  logic                 rs1_valid, rs2_valid, rd_valid, r7_dest;
  int                   in_flight;
  integer               seed;

  instr_decoder dut_i (.*);

  decode_checker chk_i (.*); // Watches DUT ports

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #((stim_cycles + 20) * clk_period);
    $display("Timeout: the decoder did not finish the stimulus in the expected run time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    int          errs;
    seed = 32'hadba;
    rst_n       <= 1'b0;
    instr_valid <= 1'b0;
    instr_word  <= '0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    // Every major opcode with every condition back to back
    for (int m = 0; m < 16; m++) begin
      for (int c = 0; c < 4; c++) begin
        rnd = $random(seed);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr_word  <= {m[3:0], rnd[9:0], c[1:0]};
      end
    end

    for (int i = 0; i < random_words; i++) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        @(posedge clk);
        instr_valid <= 1'b0;
        instr_word  <= rnd[31:16]; // Junk word while idle
      end
      rnd = $random(seed);
      @(posedge clk);
      instr_valid <= 1'b1;
      instr_word  <= rnd[15:0];
    end
    @(posedge clk);
    instr_valid <= 1'b0;

    repeat (2) @(posedge clk);
    while (in_flight != 0) @(posedge clk);
    repeat (4) @(posedge clk); // Catch any extra outputs
    @(negedge clk);
    chk_i.close_report(errs);
    if (errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
isa_pkg.sv
reg_field_decode.sv
control_decode.sv
instr_decoder.sv
instr_decoder_sva.sv
decode_checker.sv
tb_instr_decoder.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_instr_decoder -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
